// ==== fpu_normalize_round.sv ====
/*
 * Stage 3: normalization, round to nearest even, special values, compare
 * results and per-lane result select into the output register
 */
`timescale 1ns/1ps

module fpu_normalize_round
    import fpu_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int TAG_WIDTH = 4
)
(
    input logic clk,
    input logic advance,
    input fpu_op_t x_op,
    input logic [TAG_WIDTH-1:0] x_tag,
    input logic [NUM_LANES-1:0][27:0] x_sum,
    input logic [NUM_LANES-1:0] x_sum_sign,
    input logic [NUM_LANES-1:0][4:0] x_norm_shift,
    input logic [NUM_LANES-1:0][7:0] x_big_exp,
    input logic [NUM_LANES-1:0][47:0] x_product,
    input logic [NUM_LANES-1:0][9:0] x_mul_exp,
    input logic [NUM_LANES-1:0] x_mul_sign,
    input logic [NUM_LANES-1:0][31:0] x_int_product,
    input logic [NUM_LANES-1:0] x_nan,
    input logic [NUM_LANES-1:0] x_inf,
    input logic [NUM_LANES-1:0] x_inf_sign,
    input logic [NUM_LANES-1:0] x_mul_zero,
    output logic [TAG_WIDTH-1:0] out_tag,
    output float_word_t [NUM_LANES-1:0] out_result
);

    function automatic float_word_t pack_float(input logic sign, input logic [7:0] exponent,
                                               input logic [22:0] fraction);
        float_word_t result;
        result.fp.sign = sign;
        result.fp.exponent = exponent;
        result.fp.fraction = fraction;
        return result;
    endfunction

    // mant holds the 24 bit significand above guard, round and sticky
    function automatic float_word_t round_pack(input logic sign,
                                               input logic signed [9:0] exp_in,
                                               input logic [26:0] mant);
        logic round_up;
        logic [24:0] rounded;
        logic signed [9:0] exp_out;
        round_up = mant[2] && (mant[1] || mant[0] || mant[3]);
        rounded = {1'b0, mant[26:3]} + 25'(round_up);
        exp_out = rounded[24] ? exp_in + 10'sd1 : exp_in;
        // Exact magnitude below the smallest normal flushes to signed zero
        if (exp_in <= 10'sd0)
            return pack_float(sign, '0, '0);
        else if (exp_out >= 10'sd255)
            return pack_float(sign, '1, '0);
        else
            return pack_float(sign, exp_out[7:0], rounded[22:0]);
    endfunction

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : lane_gen
        logic sum_zero;
        logic [26:0] sum_left;
        logic [26:0] sum_mant;
        logic signed [9:0] sum_exp;
        logic [26:0] mul_mant;
        logic signed [9:0] mul_exp;
        logic cmp_result;
        float_word_t add_result;
        float_word_t mul_result;
        float_word_t lane_result;

        assign sum_zero = x_sum[i] == '0;
        assign sum_left = x_sum[i][26:0] << x_norm_shift[i];

        // Carry out shifts right one place, otherwise shift the leading one up to bit 26
        assign sum_mant = x_sum[i][27] ? {x_sum[i][27:2], |x_sum[i][1:0]} : sum_left;
        assign sum_exp = x_sum[i][27] ? $signed({2'b00, x_big_exp[i]}) + 10'sd1
            : $signed({2'b00, x_big_exp[i]}) - $signed({5'd0, x_norm_shift[i]});

        // Product of two normal significands is in [1, 4)
        assign mul_mant = x_product[i][47] ? {x_product[i][47:22], |x_product[i][21:0]}
            : {x_product[i][46:21], |x_product[i][20:0]};
        assign mul_exp = x_product[i][47] ? $signed(x_mul_exp[i]) + 10'sd1
            : $signed(x_mul_exp[i]);

        // Unordered compares are false
        always_comb
        begin
            case (x_op)
                OP_FCMP_LT: cmp_result = x_sum_sign[i] && !sum_zero && !x_nan[i];
                OP_FCMP_EQ: cmp_result = sum_zero && !x_nan[i];
                OP_FCMP_GT: cmp_result = !x_sum_sign[i] && !sum_zero && !x_nan[i];
                default: cmp_result = 1'b0;
            endcase
        end

        always_comb
        begin
            if (x_nan[i])
                add_result.word = CANONICAL_NAN;
            else if (x_inf[i])
                add_result = pack_float(x_inf_sign[i], '1, '0);
            else if (sum_zero)
                add_result = pack_float(1'b0, '0, '0);
            else
                add_result = round_pack(x_sum_sign[i], sum_exp, sum_mant);
        end

        always_comb
        begin
            if (x_nan[i])
                mul_result.word = CANONICAL_NAN;
            else if (x_inf[i])
                mul_result = pack_float(x_inf_sign[i], '1, '0);
            else if (x_mul_zero[i])
                mul_result = pack_float(x_mul_sign[i], '0, '0);
            else
                mul_result = round_pack(x_mul_sign[i], mul_exp, mul_mant);
        end

        always_comb
        begin
            case (x_op)
                OP_FADD, OP_FSUB: lane_result = add_result;
                OP_FMUL: lane_result = mul_result;
                OP_FCMP_LT, OP_FCMP_EQ, OP_FCMP_GT: lane_result.word = {31'd0, cmp_result};
                OP_IMUL_LO: lane_result.word = x_int_product[i];
                default: lane_result.word = '0;
            endcase
        end

        always_ff @(posedge clk)
        begin
            if (advance)
                out_result[i] <= lane_result;
        end

        no_stray_nan: assert property (@(posedge clk)
            advance && (x_op inside {OP_FADD, OP_FSUB, OP_FMUL}) && !x_nan[i]
            |-> !(&lane_result.fp.exponent && |lane_result.fp.fraction));
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            out_tag <= x_tag;
    end

endmodule

// ==== fpu_operand_unpack.sv ====
/*
 * Stage 1: operand classification, magnitude ordering and alignment for
 * add, subtract and compare, plus product exponent and sign
 */
`timescale 1ns/1ps

module fpu_operand_unpack
    import fpu_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int TAG_WIDTH = 4
)
(
    input logic clk,
    input logic advance,
    input logic in_valid,
    input fpu_op_t in_op,
    input logic [TAG_WIDTH-1:0] in_tag,
    input float_word_t [NUM_LANES-1:0] in_a,
    input float_word_t [NUM_LANES-1:0] in_b,
    output fpu_op_t u_op,
    output logic [TAG_WIDTH-1:0] u_tag,
    output logic [NUM_LANES-1:0] u_swap_sign,
    output logic [NUM_LANES-1:0][7:0] u_big_exp,
    output logic [NUM_LANES-1:0][23:0] u_big_sig,
    output logic [NUM_LANES-1:0][26:0] u_small_sig_aligned,
    output logic [NUM_LANES-1:0] u_effective_subtract,
    output logic [NUM_LANES-1:0][9:0] u_mul_exp,
    output logic [NUM_LANES-1:0] u_mul_sign,
    output logic [NUM_LANES-1:0][23:0] u_mul_sig_a,
    output logic [NUM_LANES-1:0][23:0] u_mul_sig_b,
    output logic [NUM_LANES-1:0][31:0] u_int_a,
    output logic [NUM_LANES-1:0][31:0] u_int_b,
    output logic [NUM_LANES-1:0] u_nan,
    output logic [NUM_LANES-1:0] u_inf,
    output logic [NUM_LANES-1:0] u_inf_sign,
    output logic [NUM_LANES-1:0] u_zero_a,
    output logic [NUM_LANES-1:0] u_zero_b
);

    logic is_fmul;
    logic is_cmp;
    logic negate_b;

    assign is_fmul = in_op == OP_FMUL;
    assign is_cmp = in_op inside {OP_FCMP_LT, OP_FCMP_EQ, OP_FCMP_GT};
    // Subtract and all compares work on a - b
    assign negate_b = in_op != OP_FADD;

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : lane_gen
        float_word_t a;
        float_word_t b;
        logic zero_a;
        logic zero_b;
        logic nan_a;
        logic nan_b;
        logic inf_a;
        logic inf_b;
        logic [23:0] sig_a;
        logic [23:0] sig_b;
        logic sign_b_eff;
        logic sub_op;
        logic swap;
        logic [7:0] exp_diff;
        logic [4:0] shift;
        logic [58:0] shifted;

        assign a = in_a[i];
        assign b = in_b[i];

        // Subnormals count as zero, so a zero exponent field means zero
        assign zero_a = a.fp.exponent == '0;
        assign zero_b = b.fp.exponent == '0;
        assign nan_a = &a.fp.exponent && |a.fp.fraction;
        assign nan_b = &b.fp.exponent && |b.fp.fraction;
        assign inf_a = &a.fp.exponent && !(|a.fp.fraction);
        assign inf_b = &b.fp.exponent && !(|b.fp.fraction);
        assign sig_a = zero_a ? '0 : {1'b1, a.fp.fraction};
        assign sig_b = zero_b ? '0 : {1'b1, b.fp.fraction};

        assign sign_b_eff = b.fp.sign ^ negate_b;
        assign sub_op = a.fp.sign ^ sign_b_eff;
        assign swap = {b.fp.exponent, sig_b} > {a.fp.exponent, sig_a};
        assign exp_diff = swap ? b.fp.exponent - a.fp.exponent : a.fp.exponent - b.fp.exponent;

        // Past 31 places every bit of the small operand lands in sticky anyway
        assign shift = exp_diff > 8'd31 ? 5'd31 : exp_diff[4:0];
        assign shifted = {(swap ? sig_a : sig_b), 35'd0} >> shift;

        always_ff @(posedge clk)
        begin
            if (advance)
            begin
                u_swap_sign[i] <= swap ? sign_b_eff : a.fp.sign;
                u_big_exp[i] <= swap ? b.fp.exponent : a.fp.exponent;
                u_big_sig[i] <= swap ? sig_b : sig_a;
                u_small_sig_aligned[i] <= {shifted[58:33], |shifted[32:0]};
                u_effective_subtract[i] <= sub_op;
                u_mul_exp[i] <= {2'b00, a.fp.exponent} + {2'b00, b.fp.exponent}
                    - 10'(FLOAT_BIAS);
                u_mul_sign[i] <= a.fp.sign ^ b.fp.sign;
                u_mul_sig_a[i] <= sig_a;
                u_mul_sig_b[i] <= sig_b;
                u_int_a[i] <= a.word;
                u_int_b[i] <= b.word;
                // inf - inf is invalid for add/sub, but compares order infinities normally
                u_nan[i] <= nan_a || nan_b || (is_fmul ? (inf_a && zero_b) || (zero_a && inf_b)
                    : !is_cmp && inf_a && inf_b && sub_op);
                u_inf[i] <= inf_a || inf_b;
                u_inf_sign[i] <= is_fmul ? a.fp.sign ^ b.fp.sign
                    : (inf_a ? a.fp.sign : sign_b_eff);
                u_zero_a[i] <= zero_a;
                u_zero_b[i] <= zero_b;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            u_op <= in_op;
            u_tag <= in_tag;
        end
    end

    op_code_legal: assert property (@(posedge clk)
        advance && in_valid |=> u_op inside {OP_FADD, OP_FSUB, OP_FMUL, OP_FCMP_LT,
                                             OP_FCMP_EQ, OP_FCMP_GT, OP_IMUL_LO});

endmodule

// ==== fpu_pkg.sv ====
/*
 * Shared definitions for the vector FPU: operation codes, float word
 * layout with its integer view, field widths, bias and canonical NaN
 */
package fpu_pkg;

    localparam int FLOAT_EXP_WIDTH = 8;
    localparam int FLOAT_FRAC_WIDTH = 23;
    localparam int FLOAT_BIAS = 127;

    // Result for any NaN operand or invalid operation
    localparam logic [31:0] CANONICAL_NAN = 32'h7fffffff;

    typedef enum logic [2:0]
    {
        OP_FADD = 3'd0,
        OP_FSUB = 3'd1,
        OP_FMUL = 3'd2,
        OP_FCMP_LT = 3'd3,
        OP_FCMP_EQ = 3'd4,
        OP_FCMP_GT = 3'd5,
        OP_IMUL_LO = 3'd6
    } fpu_op_t;

    // One lane operand, seen either as IEEE single fields or as a plain integer
    typedef union packed
    {
        struct packed
        {
            logic sign;
            logic [FLOAT_EXP_WIDTH-1:0] exponent;
            logic [FLOAT_FRAC_WIDTH-1:0] fraction;
        } fp;
        logic [FLOAT_EXP_WIDTH+FLOAT_FRAC_WIDTH:0] word;
    } float_word_t;

endpackage

// ==== fpu_significand_ops.sv ====
/*
 * Stage 2: aligned significand add or subtract, leading zero count of the
 * sum, float and integer products
 */
`timescale 1ns/1ps

module fpu_significand_ops
    import fpu_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int TAG_WIDTH = 4
)
(
    input logic clk,
    input logic advance,
    input fpu_op_t u_op,
    input logic [TAG_WIDTH-1:0] u_tag,
    input logic [NUM_LANES-1:0] u_swap_sign,
    input logic [NUM_LANES-1:0][7:0] u_big_exp,
    input logic [NUM_LANES-1:0][23:0] u_big_sig,
    input logic [NUM_LANES-1:0][26:0] u_small_sig_aligned,
    input logic [NUM_LANES-1:0] u_effective_subtract,
    input logic [NUM_LANES-1:0][9:0] u_mul_exp,
    input logic [NUM_LANES-1:0] u_mul_sign,
    input logic [NUM_LANES-1:0][23:0] u_mul_sig_a,
    input logic [NUM_LANES-1:0][23:0] u_mul_sig_b,
    input logic [NUM_LANES-1:0][31:0] u_int_a,
    input logic [NUM_LANES-1:0][31:0] u_int_b,
    input logic [NUM_LANES-1:0] u_nan,
    input logic [NUM_LANES-1:0] u_inf,
    input logic [NUM_LANES-1:0] u_inf_sign,
    input logic [NUM_LANES-1:0] u_zero_a,
    input logic [NUM_LANES-1:0] u_zero_b,
    output fpu_op_t x_op,
    output logic [TAG_WIDTH-1:0] x_tag,
    output logic [NUM_LANES-1:0][27:0] x_sum,
    output logic [NUM_LANES-1:0] x_sum_sign,
    output logic [NUM_LANES-1:0][4:0] x_norm_shift,
    output logic [NUM_LANES-1:0][7:0] x_big_exp,
    output logic [NUM_LANES-1:0][47:0] x_product,
    output logic [NUM_LANES-1:0][9:0] x_mul_exp,
    output logic [NUM_LANES-1:0] x_mul_sign,
    output logic [NUM_LANES-1:0][31:0] x_int_product,
    output logic [NUM_LANES-1:0] x_nan,
    output logic [NUM_LANES-1:0] x_inf,
    output logic [NUM_LANES-1:0] x_inf_sign,
    output logic [NUM_LANES-1:0] x_mul_zero
);

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : lane_gen
        logic [27:0] big_ext;
        logic [27:0] small_ext;
        logic [27:0] sum;
        logic [4:0] lead_zeros;

        // Bit 27 catches carry out, bits 2:0 are guard, round and sticky
        assign big_ext = {1'b0, u_big_sig[i], 3'b000};
        assign small_ext = {1'b0, u_small_sig_aligned[i]};

        // Operands are ordered by magnitude, so the difference never goes negative
        assign sum = u_effective_subtract[i] ? big_ext - small_ext : big_ext + small_ext;

        // Distance of the leading one from bit 26, 27 when the sum is zero
        always_comb
        begin
            lead_zeros = 5'd27;
            for (int k = 0; k < 27; k++)
            begin
                if (sum[k])
                    lead_zeros = 5'(26 - k);
            end
        end

        always_ff @(posedge clk)
        begin
            if (advance)
            begin
                x_sum[i] <= sum;
                x_sum_sign[i] <= u_swap_sign[i];
                x_norm_shift[i] <= lead_zeros;
                x_big_exp[i] <= u_big_exp[i];
                x_product[i] <= u_mul_sig_a[i] * u_mul_sig_b[i];
                x_mul_exp[i] <= u_mul_exp[i];
                x_mul_sign[i] <= u_mul_sign[i];
                x_int_product[i] <= u_int_a[i] * u_int_b[i];
                x_nan[i] <= u_nan[i];
                x_inf[i] <= u_inf[i];
                x_inf_sign[i] <= u_inf_sign[i];
                x_mul_zero[i] <= u_zero_a[i] || u_zero_b[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            x_op <= u_op;
            x_tag <= u_tag;
        end
    end

endmodule

// ==== fpu_stall_control.sv ====
/*
 * Pipeline occupancy bits and the global advance enable for the vector FPU
 */
`timescale 1ns/1ps

module fpu_stall_control
(
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic out_ready,
    output logic in_ready,
    output logic advance,
    output logic out_valid
);

    logic s1_valid;
    logic s2_valid;
    logic s3_valid;

    // Whole pipeline freezes only when a finished result is refused
    assign advance = !(s3_valid && !out_ready);
    assign in_ready = advance;
    assign out_valid = s3_valid;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end
        else if (advance)
        begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    out_valid_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid);

endmodule

// ==== vector_fpu.f ====
fpu_pkg.sv
fpu_stall_control.sv
fpu_operand_unpack.sv
fpu_significand_ops.sv
fpu_normalize_round.sv
vector_fpu.sv
vector_fpu_checker.sv
vector_fpu_tb.sv

// ==== vector_fpu.sv ====
/*
 * Vector FPU top level: stall control and the three pipeline stages
 */
`timescale 1ns/1ps

module vector_fpu
    import fpu_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int TAG_WIDTH = 4
)
(
    input logic clk,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input fpu_op_t in_op,
    input logic [TAG_WIDTH-1:0] in_tag,
    input float_word_t [NUM_LANES-1:0] in_a,
    input float_word_t [NUM_LANES-1:0] in_b,
    output logic out_valid,
    input logic out_ready,
    output logic [TAG_WIDTH-1:0] out_tag,
    output float_word_t [NUM_LANES-1:0] out_result
);

    logic advance;

    // Stage 1 to stage 2
    fpu_op_t u_op;
    logic [TAG_WIDTH-1:0] u_tag;
    logic [NUM_LANES-1:0] u_swap_sign;
    logic [NUM_LANES-1:0][7:0] u_big_exp;
    logic [NUM_LANES-1:0][23:0] u_big_sig;
    logic [NUM_LANES-1:0][26:0] u_small_sig_aligned;
    logic [NUM_LANES-1:0] u_effective_subtract;
    logic [NUM_LANES-1:0][9:0] u_mul_exp;
    logic [NUM_LANES-1:0] u_mul_sign;
    logic [NUM_LANES-1:0][23:0] u_mul_sig_a;
    logic [NUM_LANES-1:0][23:0] u_mul_sig_b;
    logic [NUM_LANES-1:0][31:0] u_int_a;
    logic [NUM_LANES-1:0][31:0] u_int_b;
    logic [NUM_LANES-1:0] u_nan;
    logic [NUM_LANES-1:0] u_inf;
    logic [NUM_LANES-1:0] u_inf_sign;
    logic [NUM_LANES-1:0] u_zero_a;
    logic [NUM_LANES-1:0] u_zero_b;

    // Stage 2 to stage 3
    fpu_op_t x_op;
    logic [TAG_WIDTH-1:0] x_tag;
    logic [NUM_LANES-1:0][27:0] x_sum;
    logic [NUM_LANES-1:0] x_sum_sign;
    logic [NUM_LANES-1:0][4:0] x_norm_shift;
    logic [NUM_LANES-1:0][7:0] x_big_exp;
    logic [NUM_LANES-1:0][47:0] x_product;
    logic [NUM_LANES-1:0][9:0] x_mul_exp;
    logic [NUM_LANES-1:0] x_mul_sign;
    logic [NUM_LANES-1:0][31:0] x_int_product;
    logic [NUM_LANES-1:0] x_nan;
    logic [NUM_LANES-1:0] x_inf;
    logic [NUM_LANES-1:0] x_inf_sign;
    logic [NUM_LANES-1:0] x_mul_zero;

    fpu_stall_control fpu_stall_control_inst(.*);

    fpu_operand_unpack #(
        .NUM_LANES(NUM_LANES),
        .TAG_WIDTH(TAG_WIDTH)
    ) fpu_operand_unpack_inst(.*);

    fpu_significand_ops #(
        .NUM_LANES(NUM_LANES),
        .TAG_WIDTH(TAG_WIDTH)
    ) fpu_significand_ops_inst(.*);

    fpu_normalize_round #(
        .NUM_LANES(NUM_LANES),
        .TAG_WIDTH(TAG_WIDTH)
    ) fpu_normalize_round_inst(.*);

endmodule

// ==== vector_fpu_checker.sv ====
/*
 * Vector FPU checker: reference model of the lane operations, expected
 * result queue, handshake, tag, lane and latency comparisons
 */
`timescale 1ns/1ps

module vector_fpu_checker
    import fpu_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int TAG_WIDTH = 4
)
(
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic in_ready,
    input logic [2:0] in_op,
    input logic [TAG_WIDTH-1:0] in_tag,
    input logic [NUM_LANES*32-1:0] in_a,
    input logic [NUM_LANES*32-1:0] in_b,
    input logic out_valid,
    input logic out_ready,
    input logic [TAG_WIDTH-1:0] out_tag,
    input logic [NUM_LANES*32-1:0] out_result,
    output int error_count,
    output int checked_count,
    output int pending_count
);

    logic [TAG_WIDTH-1:0] tag_q[$];
    logic [NUM_LANES*32-1:0] result_q[$];
    logic [2:0] op_q[$];
    longint cycle_q[$];
    longint stall_q[$];
    longint cycle;
    longint stall_cycles;
    // Expected occupancy of the three stages, last stage in bit 2
    logic [2:0] stage_valid;
    logic expected_ready;

    // Flushed value of a non-NaN single; infinities map to double infinities
    function automatic real float_to_real(input logic [31:0] f);
        if (f[30:23] == 8'd0)
            return 0.0;
        else if (f[30:23] == 8'hff)
            return $bitstoreal({f[31], 11'h7ff, 52'd0});
        else
            return $bitstoreal({f[31], {3'd0, f[30:23]} + 11'd896, f[22:0], 29'd0});
    endfunction

    // Nearest-even single of a nonzero double, tiny magnitudes go to signed zero
    function automatic logic [31:0] round_to_single(input real r);
        logic [63:0] d;
        logic [24:0] sig;
        logic up;
        int e;
        d = $realtobits(r);
        e = d[62:52];
        e = e - 1023;
        if (e < -126)
            return {d[63], 31'd0};
        up = d[28] && (|d[27:0] || d[29]);
        sig = {2'b01, d[51:29]} + 25'(up);
        if (sig[24])
            e++;
        if (e > 127)
            return {d[63], 8'hff, 23'd0};
        return {d[63], 8'(e + 127), sig[22:0]};
    endfunction

    function automatic logic [31:0] expected_lane(input logic [2:0] op, input logic [31:0] a,
                                                  input logic [31:0] b);
        logic nan_a;
        logic nan_b;
        logic inf_a;
        logic inf_b;
        logic zero_a;
        logic zero_b;
        logic sign_b;
        real ra;
        real rb;
        real r;
        nan_a = &a[30:23] && |a[22:0];
        nan_b = &b[30:23] && |b[22:0];
        inf_a = &a[30:23] && !(|a[22:0]);
        inf_b = &b[30:23] && !(|b[22:0]);
        zero_a = a[30:23] == 8'd0;
        zero_b = b[30:23] == 8'd0;
        ra = float_to_real(a);
        rb = float_to_real(b);
        sign_b = b[31] ^ (op != OP_FADD);
        case (op)
            OP_IMUL_LO: return a * b;
            OP_FCMP_LT: return {31'd0, !nan_a && !nan_b && (ra < rb)};
            OP_FCMP_EQ: return {31'd0, !nan_a && !nan_b && (ra == rb)};
            OP_FCMP_GT: return {31'd0, !nan_a && !nan_b && (ra > rb)};
            OP_FMUL:
            begin
                if (nan_a || nan_b || (inf_a && zero_b) || (zero_a && inf_b))
                    return CANONICAL_NAN;
                if (inf_a || inf_b)
                    return {a[31] ^ b[31], 8'hff, 23'd0};
                if (zero_a || zero_b)
                    return {a[31] ^ b[31], 31'd0};
                return round_to_single(ra * rb);
            end
            OP_FADD, OP_FSUB:
            begin
                if (nan_a || nan_b || (inf_a && inf_b && a[31] != sign_b))
                    return CANONICAL_NAN;
                if (inf_a)
                    return {a[31], 8'hff, 23'd0};
                if (inf_b)
                    return {sign_b, 8'hff, 23'd0};
                r = (op == OP_FADD) ? ra + rb : ra - rb;
                if (r == 0.0)
                    return 32'd0;
                return round_to_single(r);
            end
            default: return 32'd0;
        endcase
    endfunction

    task automatic accept_request();
        logic [NUM_LANES*32-1:0] expected;
        for (int i = 0; i < NUM_LANES; i++)
            expected[i*32 +: 32] = expected_lane(in_op, in_a[i*32 +: 32], in_b[i*32 +: 32]);
        tag_q.push_back(in_tag);
        result_q.push_back(expected);
        op_q.push_back(in_op);
        cycle_q.push_back(cycle);
        stall_q.push_back(stall_cycles);
    endtask

    task automatic check_result();
        logic [TAG_WIDTH-1:0] tag;
        logic [NUM_LANES*32-1:0] expected;
        logic [2:0] op;
        longint latency;
        longint allowed;
        if (tag_q.size() == 0)
        begin
            $display("Result with tag %h left the DUT with no request outstanding", out_tag);
            error_count++;
            return;
        end
        tag = tag_q.pop_front();
        expected = result_q.pop_front();
        op = op_q.pop_front();
        latency = cycle - cycle_q.pop_front();
        // Three stages plus one cycle for every stalled edge since acceptance
        allowed = 3 + stall_cycles - stall_q.pop_front();
        checked_count++;
        if (out_tag !== tag)
        begin
            $display("Fail out_tag: got %h expected %h", out_tag, tag);
            error_count++;
        end
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if (out_result[i*32 +: 32] !== expected[i*32 +: 32])
            begin
                $display("Fail out_result lane %0d tag %h op %h: got %h expected %h",
                         i, tag, op, out_result[i*32 +: 32], expected[i*32 +: 32]);
                error_count++;
            end
        end
        if (latency != allowed)
        begin
            $display("Result for tag %h arrived after %0d cycles instead of %0d",
                     tag, latency, allowed);
            error_count++;
        end
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            tag_q.delete();
            result_q.delete();
            op_q.delete();
            cycle_q.delete();
            stall_q.delete();
            cycle = 0;
            stall_cycles = 0;
            error_count = 0;
            checked_count = 0;
            stage_valid = '0;
        end
        else
        begin
            // The pipeline holds only while a finished result is refused
            expected_ready = !(stage_valid[2] && !out_ready);
            if (out_valid !== stage_valid[2])
            begin
                $display("Fail out_valid: got %h expected %h", out_valid, stage_valid[2]);
                error_count++;
            end
            if (in_ready !== expected_ready)
            begin
                $display("Fail in_ready: got %h expected %h", in_ready, expected_ready);
                error_count++;
            end
            if (in_valid && in_ready)
                accept_request();
            if (out_valid && out_ready)
                check_result();
            cycle++;
            if (!in_ready)
                stall_cycles++;
            if (expected_ready)
                stage_valid = {stage_valid[1:0], in_valid};
        end
        pending_count = tag_q.size();
    end

endmodule

// ==== vector_fpu_tb.sv ====
/*
 * Vector FPU testbench: clock, reset, seeded random requests under random
 * back-pressure, watchdog and closing report
 */
`timescale 1ns/1ps

module vector_fpu_tb
    import fpu_pkg::*;
();

    localparam int NUM_LANES = 4;
    localparam int TAG_WIDTH = 4;
    localparam int CLK_PERIOD = 100;
    localparam int NUM_REQUESTS = 2000;
    // Requests sent with out_ready held high, to see the bare pipeline latency
    localparam int READY_PHASE = 200;
    // Cycles allowed for the last results to leave after the final request
    localparam int DRAIN_LIMIT = 100;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    fpu_op_t in_op;
    logic [TAG_WIDTH-1:0] in_tag;
    float_word_t [NUM_LANES-1:0] in_a;
    float_word_t [NUM_LANES-1:0] in_b;
    logic out_valid;
    logic out_ready;
    logic [TAG_WIDTH-1:0] out_tag;
    float_word_t [NUM_LANES-1:0] out_result;
    int error_count;
    int checked_count;
    int pending_count;
    integer seed;
    int sent;
    int total_errors;
    int drain_cycles;
    logic accepted;

    vector_fpu #(
        .NUM_LANES(NUM_LANES),
        .TAG_WIDTH(TAG_WIDTH)
    ) vector_fpu_inst (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_op(in_op),
        .in_tag(in_tag),
        .in_a(in_a),
        .in_b(in_b),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_tag(out_tag),
        .out_result(out_result)
    );

    vector_fpu_checker #(
        .NUM_LANES(NUM_LANES),
        .TAG_WIDTH(TAG_WIDTH)
    ) vector_fpu_checker_inst (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_op(in_op),
        .in_tag(in_tag),
        .in_a(in_a),
        .in_b(in_b),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_tag(out_tag),
        .out_result(out_result),
        .error_count(error_count),
        .checked_count(checked_count),
        .pending_count(pending_count)
    );

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // Normal value with exponent in base .. base+spread-1
    function automatic logic [31:0] normal_value(input int base, input int spread);
        logic [31:0] r;
        r = next_random();
        return {r[31], 8'(base + r[30:23] % spread), r[22:0]};
    endfunction

    // Zero, infinity, NaN or subnormal
    function automatic logic [31:0] special_value();
        logic [31:0] r;
        r = next_random();
        case (r[1:0])
            2'd0: return {r[31], 31'd0};
            2'd1: return {r[31], 8'hff, 23'd0};
            2'd2: return {r[31], 8'hff, r[24:3], 1'b1};
            default: return {r[31], 8'h00, r[24:2]};
        endcase
    endfunction

    // Exponent close to underflow or overflow, often with an all ones fraction
    function automatic logic [31:0] limit_value();
        logic [31:0] r;
        logic [31:0] f;
        logic [7:0] exponent;
        r = next_random();
        f = next_random();
        exponent = r[8] ? 8'd245 + 8'(r[3:0] % 10) : 8'd1 + 8'(r[2:0]);
        return {r[31], exponent, r[9] ? 23'h7fffff - 23'(f[2:0]) : f[22:0]};
    endfunction

    task automatic make_request();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        in_op = fpu_op_t'(next_random() % 7);
        in_tag = sent[TAG_WIDTH-1:0];
        for (int i = 0; i < NUM_LANES; i++)
        begin
            r = next_random();
            case (r[2:0])
                3'd0, 3'd1:
                begin
                    a = normal_value(120, 15);
                    b = normal_value(120, 15);
                end
                3'd2:
                begin
                    a = normal_value(120, 15);
                    b = a;
                end
                3'd3:
                begin
                    a = normal_value(120, 15);
                    b = a ^ 32'h8000_0000;
                end
                3'd4:
                begin
                    a = special_value();
                    b = special_value();
                end
                3'd5:
                begin
                    a = normal_value(1, 254);
                    b = special_value();
                end
                3'd6:
                begin
                    a = limit_value();
                    b = limit_value();
                end
                default:
                begin
                    a = next_random();
                    b = next_random();
                end
            endcase
            in_a[i] = a;
            in_b[i] = b;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(CLK_PERIOD * (NUM_REQUESTS * 20 + 100));
        $display("Watchdog timeout with %0d requests still outstanding and %0d results checked",
                 pending_count, checked_count);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        seed = 32'hb844_c9c8;
        reset = 1'b1;
        in_valid = 1'b0;
        in_op = OP_FADD;
        in_tag = '0;
        in_a = '0;
        in_b = '0;
        out_ready = 1'b0;
        sent = 0;
        repeat (16) @(posedge clk);
        #10;
        reset = 1'b0;

        while (sent < NUM_REQUESTS)
        begin
            @(posedge clk);
            accepted = in_valid && in_ready;
            #10;
            if (accepted)
                sent++;
            // A request still waiting for in_ready keeps its payload
            if (accepted || !in_valid)
            begin
                if (sent < NUM_REQUESTS && next_random() % 10 < 7)
                begin
                    make_request();
                    in_valid = 1'b1;
                end
                else
                    in_valid = 1'b0;
            end
            out_ready = (sent < READY_PHASE) || (next_random() % 10 < 7);
        end

        // Drain what is still in the pipeline
        drain_cycles = 0;
        while (pending_count > 0 && drain_cycles < DRAIN_LIMIT)
        begin
            @(posedge clk);
            #10;
            out_ready = next_random() % 10 < 7;
            drain_cycles++;
        end
        out_ready = 1'b1;
        repeat (8) @(posedge clk);
        #10;

        total_errors = error_count;
        if (pending_count != 0)
        begin
            $display("%0d accepted requests never produced a result", pending_count);
            total_errors++;
        end
        $display("Requests %0d, results checked %0d, errors %0d",
                 NUM_REQUESTS, checked_count, total_errors);
        if (total_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
